// ==== rtl/muldiv_pkg.sv ====
// rv64m multiply/divide shared definitions
`default_nettype none

package muldiv_pkg;

  // ==========================================================
  // widths
  // ==========================================================
  localparam int XLEN       = 64;
  localparam int WORD_ITERS = 32;  // steps for the *w forms

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [3:0]      md_op_t;
  typedef logic [2:0]      md_tag_t;
  typedef logic [6:0]      iter_cnt_t;  // holds up to XLEN

  // ==========================================================
  // operation codes
  // ==========================================================
  localparam md_op_t OP_MUL    = 4'h0;
  localparam md_op_t OP_MULH   = 4'h1;
  localparam md_op_t OP_MULHSU = 4'h2;
  localparam md_op_t OP_MULHU  = 4'h3;
  localparam md_op_t OP_MULW   = 4'h4;
  localparam md_op_t OP_DIV    = 4'h8;  // divider ops have bit 3 set
  localparam md_op_t OP_DIVU   = 4'h9;
  localparam md_op_t OP_DIVW   = 4'ha;
  localparam md_op_t OP_DIVUW  = 4'hb;
  localparam md_op_t OP_REM    = 4'hc;
  localparam md_op_t OP_REMU   = 4'hd;
  localparam md_op_t OP_REMW   = 4'he;
  localparam md_op_t OP_REMUW  = 4'hf;

  // engine fsm, shared by multiplier and divider
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_BUSY,
    ENG_DONE
  } md_eng_state_t;

endpackage

`default_nettype wire

// ==== rtl/md_dispatch.sv ====
// multiply/divide request dispatcher
`timescale 1ns/1ps
`default_nettype none

module md_dispatch (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  input  muldiv_pkg::md_op_t req_op_i,
  input  logic               mul_busy_i,
  input  logic               div_busy_i,
  output logic               stall_o,
  output logic               mul_start_o,
  output logic               div_start_o
);
  import muldiv_pkg::*;

  logic is_div;
  logic accept;
  logic mul_pend_q;  // start issued, busy not yet up
  logic div_pend_q;

  always_comb begin
    is_div = req_op_i inside {OP_DIV, OP_DIVU, OP_DIVW, OP_DIVUW,
                              OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  end

  // stall on the engine this op needs
  assign stall_o = is_div ? (div_busy_i | div_pend_q) : (mul_busy_i | mul_pend_q);
  assign accept  = req_valid_i & ~stall_o;

  // registered starts, each also acts as the pending bit for one cycle
  always_ff @(posedge clk) begin
    if (rst_n) begin
      mul_pend_q <= 1'b0;
      div_pend_q <= 1'b0;
    end else begin
      mul_pend_q <= accept & ~is_div;
      div_pend_q <= accept & is_div;
    end
  end

  assign mul_start_o = mul_pend_q;
  assign div_start_o = div_pend_q;

endmodule

`default_nettype wire

// ==== rtl/md_divider.sv ====
// restoring radix-2 divider
`timescale 1ns/1ps
`default_nettype none

module md_divider (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  muldiv_pkg::md_op_t  op_i,
  input  muldiv_pkg::xlen_t   a_i,
  input  muldiv_pkg::xlen_t   b_i,
  input  muldiv_pkg::md_tag_t tag_i,
  input  logic                grant_i,
  output logic                busy_o,
  output logic                done_o,
  output muldiv_pkg::xlen_t   result_o,
  output muldiv_pkg::md_tag_t tag_o
);
  import muldiv_pkg::*;

  md_eng_state_t state_q;
  iter_cnt_t     cnt_q;

  // request copy, follows the inputs while idle, frozen once started
  md_op_t  op_q;
  xlen_t   a_q;
  xlen_t   b_q;
  md_tag_t tag_q;

  logic [2*XLEN-1:0] rq_q;  // {remainder, quotient}
  xlen_t             dvs_q;
  logic              q_neg_q;
  logic              r_neg_q;

  logic          is_word, is_signed, is_rem;
  xlen_t         dvd, dvs, min_neg;
  logic          dvd_neg, dvs_neg;
  xlen_t         dvd_abs, dvs_abs;
  logic          div_zero, div_ovf;
  logic [XLEN:0] diff;
  xlen_t         quo, rem, sel;

  // ==========================================================
  // operand prep and exception detect
  // ==========================================================
  always_comb begin
    is_word   = op_q inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
    is_signed = op_q inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};
    is_rem    = op_q inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};
    if (is_word) begin
      dvd     = is_signed ? {{32{a_q[31]}}, a_q[31:0]} : {32'b0, a_q[31:0]};
      dvs     = is_signed ? {{32{b_q[31]}}, b_q[31:0]} : {32'b0, b_q[31:0]};
      min_neg = {{33{1'b1}}, 31'b0};  // sext of 0x8000_0000
    end else begin
      dvd     = a_q;
      dvs     = b_q;
      min_neg = {1'b1, {(XLEN-1){1'b0}}};
    end
    dvd_neg  = is_signed & dvd[XLEN-1];
    dvs_neg  = is_signed & dvs[XLEN-1];
    dvd_abs  = dvd_neg ? -dvd : dvd;
    dvs_abs  = dvs_neg ? -dvs : dvs;
    div_zero = (dvs == '0);
    div_ovf  = is_signed && (dvd == min_neg) && (dvs == '1);
  end

  // one restoring step, bit XLEN of diff is the borrow
  assign diff = rq_q[2*XLEN-1:XLEN-1] - {1'b0, dvs_q};

  // ==========================================================
  // control fsm
  // ==========================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= ENG_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ENG_IDLE: begin
          if (start_i) begin
            state_q <= (div_zero | div_ovf) ? ENG_DONE : ENG_BUSY;  // shortcut
            cnt_q   <= is_word ? iter_cnt_t'(WORD_ITERS) : iter_cnt_t'(XLEN);
          end
        end
        ENG_BUSY: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == iter_cnt_t'(1)) state_q <= ENG_DONE;
        end
        ENG_DONE: if (grant_i) state_q <= ENG_IDLE;
        default:  state_q <= ENG_IDLE;
      endcase
    end
  end

  // ==========================================================
  // datapath
  // ==========================================================
  always_ff @(posedge clk) begin
    if (state_q == ENG_IDLE && !start_i) begin
      op_q  <= op_i;
      a_q   <= a_i;
      b_q   <= b_i;
      tag_q <= tag_i;
    end
    if (state_q == ENG_IDLE && start_i) begin
      if (div_zero) begin
        rq_q    <= {dvd, {XLEN{1'b1}}};  // rem = dividend, quo = all ones
        q_neg_q <= 1'b0;
        r_neg_q <= 1'b0;
      end else if (div_ovf) begin
        rq_q    <= {{XLEN{1'b0}}, dvd};  // rem = 0, quo = dividend
        q_neg_q <= 1'b0;
        r_neg_q <= 1'b0;
      end else begin
        // word dividend sits in the top half so 32 steps drain it
        rq_q    <= is_word ? {{XLEN{1'b0}}, dvd_abs[31:0], 32'b0} : {{XLEN{1'b0}}, dvd_abs};
        q_neg_q <= dvd_neg ^ dvs_neg;
        r_neg_q <= dvd_neg;
      end
      dvs_q <= dvs_abs;
    end else if (state_q == ENG_BUSY) begin
      if (diff[XLEN]) begin
        rq_q <= {rq_q[2*XLEN-2:0], 1'b0};  // restore
      end else begin
        rq_q <= {diff[XLEN-1:0], rq_q[XLEN-2:0], 1'b1};
      end
    end
  end

  // sign fixup and result select
  always_comb begin
    quo      = q_neg_q ? -rq_q[XLEN-1:0] : rq_q[XLEN-1:0];
    rem      = r_neg_q ? -rq_q[2*XLEN-1:XLEN] : rq_q[2*XLEN-1:XLEN];
    sel      = is_rem ? rem : quo;
    result_o = is_word ? {{32{sel[31]}}, sel[31:0]} : sel;
  end

  assign busy_o = (state_q != ENG_IDLE);
  assign done_o = (state_q == ENG_DONE);
  assign tag_o  = tag_q;

endmodule

`default_nettype wire

// ==== rtl/md_multiplier.sv ====
// radix-2 shift-add multiplier
`timescale 1ns/1ps
`default_nettype none

module md_multiplier (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  muldiv_pkg::md_op_t  op_i,
  input  muldiv_pkg::xlen_t   a_i,
  input  muldiv_pkg::xlen_t   b_i,
  input  muldiv_pkg::md_tag_t tag_i,
  input  logic                grant_i,
  output logic                busy_o,
  output logic                done_o,
  output muldiv_pkg::xlen_t   result_o,
  output muldiv_pkg::md_tag_t tag_o
);
  import muldiv_pkg::*;

  md_eng_state_t state_q;
  iter_cnt_t     cnt_q;

  // request copy, frozen from start until back in idle
  md_op_t  op_q;
  xlen_t   a_q;
  xlen_t   b_q;
  md_tag_t tag_q;

  logic [2*XLEN-1:0] acc_q;  // {partial product, multiplier}

  logic              a_signed, b_signed, neg;
  xlen_t             a_mag, b_mag;
  logic [XLEN:0]     psum;
  logic [2*XLEN-1:0] prod;

  always_comb begin
    a_signed = op_q inside {OP_MULH, OP_MULHSU};
    b_signed = (op_q == OP_MULH);
    neg      = (a_signed & a_q[XLEN-1]) ^ (b_signed & b_q[XLEN-1]);
    if (op_q == OP_MULW) begin
      a_mag = {32'b0, a_q[31:0]};  // low word only
      b_mag = {32'b0, b_q[31:0]};
    end else begin
      a_mag = (a_signed && a_q[XLEN-1]) ? -a_q : a_q;
      b_mag = (b_signed && b_q[XLEN-1]) ? -b_q : b_q;
    end
  end

  // add multiplicand when the current multiplier bit is set
  assign psum = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, a_mag} : '0);

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= ENG_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ENG_IDLE: begin
          if (start_i) begin
            state_q <= ENG_BUSY;
            cnt_q   <= (op_q == OP_MULW) ? iter_cnt_t'(WORD_ITERS) : iter_cnt_t'(XLEN);
          end
        end
        ENG_BUSY: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == iter_cnt_t'(1)) state_q <= ENG_DONE;  // last step
        end
        ENG_DONE: if (grant_i) state_q <= ENG_IDLE;
        default:  state_q <= ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ENG_IDLE && !start_i) begin
      op_q  <= op_i;
      a_q   <= a_i;
      b_q   <= b_i;
      tag_q <= tag_i;
    end
    if (state_q == ENG_IDLE && start_i) begin
      acc_q <= {{XLEN{1'b0}}, b_mag};
    end else if (state_q == ENG_BUSY) begin
      acc_q <= {psum, acc_q[XLEN-1:1]};
    end
  end

  // after 32 steps the word product sits at acc_q[95:32]
  always_comb begin
    prod = neg ? -acc_q : acc_q;
    case (op_q)
      OP_MULH, OP_MULHSU, OP_MULHU: result_o = prod[2*XLEN-1:XLEN];
      OP_MULW:                      result_o = {{32{acc_q[63]}}, acc_q[63:32]};
      default:                      result_o = prod[XLEN-1:0];
    endcase
  end

  assign busy_o = (state_q != ENG_IDLE);
  assign done_o = (state_q == ENG_DONE);
  assign tag_o  = tag_q;

endmodule

`default_nettype wire

// ==== rtl/md_result_arbiter.sv ====
// round-robin result port arbiter
`timescale 1ns/1ps
`default_nettype none

module md_result_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                mul_done_i,
  input  muldiv_pkg::xlen_t   mul_result_i,
  input  muldiv_pkg::md_tag_t mul_tag_i,
  input  logic                div_done_i,
  input  muldiv_pkg::xlen_t   div_result_i,
  input  muldiv_pkg::md_tag_t div_tag_i,
  input  logic                res_ready_i,
  output logic                mul_grant_o,
  output logic                div_grant_o,
  output logic                res_ok_o,
  output muldiv_pkg::xlen_t   res_data_o,
  output muldiv_pkg::md_tag_t res_tag_o
);

  logic rr_div_q;  // divider wins a tie
  logic sel_div;

  assign sel_div     = div_done_i & (~mul_done_i | rr_div_q);
  assign res_ok_o    = mul_done_i | div_done_i;
  assign res_data_o  = sel_div ? div_result_i : mul_result_i;
  assign res_tag_o   = sel_div ? div_tag_i : mul_tag_i;
  assign mul_grant_o = res_ok_o & ~sel_div & res_ready_i;
  assign div_grant_o = res_ok_o & sel_div & res_ready_i;

  // pointer sticks to a waiting result so the port holds, flips on each grant
  always_ff @(posedge clk) begin
    if (rst_n) begin
      rr_div_q <= 1'b0;
    end else if (res_ok_o) begin
      rr_div_q <= res_ready_i ? ~sel_div : sel_div;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/muldiv_unit.sv ====
// rv64m multiply/divide unit top
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid_i,
  input  muldiv_pkg::md_op_t  req_op_i,
  input  muldiv_pkg::xlen_t   req_a_i,
  input  muldiv_pkg::xlen_t   req_b_i,
  input  muldiv_pkg::md_tag_t req_tag_i,
  output logic                stall_o,
  output logic                res_ok_o,
  output muldiv_pkg::xlen_t   res_data_o,
  output muldiv_pkg::md_tag_t res_tag_o,
  input  logic                res_ready_i
);
  import muldiv_pkg::*;

  logic    mul_start, div_start;
  logic    mul_busy, div_busy;
  logic    mul_done, div_done;
  logic    mul_grant, div_grant;
  xlen_t   mul_result, div_result;
  md_tag_t mul_tag, div_tag;

  md_dispatch u_dispatch (
    .clk(clk), .rst_n(rst_n),
    .req_valid_i(req_valid_i), .req_op_i(req_op_i),
    .mul_busy_i(mul_busy), .div_busy_i(div_busy),
    .stall_o(stall_o),
    .mul_start_o(mul_start), .div_start_o(div_start)
  );

  // operands go to both engines, only the started one takes them
  md_multiplier u_mul (
    .clk(clk), .rst_n(rst_n), .start_i(mul_start),
    .op_i(req_op_i), .a_i(req_a_i), .b_i(req_b_i), .tag_i(req_tag_i),
    .grant_i(mul_grant), .busy_o(mul_busy), .done_o(mul_done),
    .result_o(mul_result), .tag_o(mul_tag)
  );

  md_divider u_div (
    .clk(clk), .rst_n(rst_n), .start_i(div_start),
    .op_i(req_op_i), .a_i(req_a_i), .b_i(req_b_i), .tag_i(req_tag_i),
    .grant_i(div_grant), .busy_o(div_busy), .done_o(div_done),
    .result_o(div_result), .tag_o(div_tag)
  );

  md_result_arbiter u_arb (
    .clk(clk), .rst_n(rst_n),
    .mul_done_i(mul_done), .mul_result_i(mul_result), .mul_tag_i(mul_tag),
    .div_done_i(div_done), .div_result_i(div_result), .div_tag_i(div_tag),
    .res_ready_i(res_ready_i),
    .mul_grant_o(mul_grant), .div_grant_o(div_grant),
    .res_ok_o(res_ok_o), .res_data_o(res_data_o), .res_tag_o(res_tag_o)
  );

endmodule

`default_nettype wire

// ==== verification/md_checker.sv ====
// muldiv result checker
`timescale 1ns/1ps
`default_nettype none

module md_checker (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid_i,
  input  muldiv_pkg::md_op_t  req_op_i,
  input  muldiv_pkg::xlen_t   req_a_i,
  input  muldiv_pkg::xlen_t   req_b_i,
  input  muldiv_pkg::md_tag_t req_tag_i,
  input  logic                stall_i,
  input  logic                res_ok_i,
  input  muldiv_pkg::xlen_t   res_data_i,
  input  muldiv_pkg::md_tag_t res_tag_i,
  input  logic                res_ready_i,
  output int                  pend_cnt_o,
  output int                  res_cnt_o,
  output int                  err_cnt_o,
  output muldiv_pkg::md_tag_t last_tag_o
);
  import muldiv_pkg::*;

  xlen_t   exp_data [8];
  logic    pending  [8] = '{default: 1'b0};  // one slot per tag
  int      pend_cnt = 0;
  int      res_cnt  = 0;
  int      err_cnt  = 0;
  md_tag_t last_tag = '0;

  function automatic xlen_t sext_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  // ==========================================================
  // reference model from the rv64m rules
  // ==========================================================
  function automatic xlen_t isa_result(input md_op_t op, input xlen_t a, input xlen_t b);
    logic signed [127:0] sa, sb, sp;
    logic [127:0]        ua, ub, up;
    logic signed [63:0]  sa64, sb64;
    logic signed [31:0]  sa32, sb32;
    logic [31:0]         ua32, ub32;
    logic                ovf64, ovf32;
    sa    = {{64{a[63]}}, a};
    sb    = {{64{b[63]}}, b};
    ua    = {64'b0, a};
    ub    = {64'b0, b};
    sa64  = a;
    sb64  = b;
    ua32  = a[31:0];
    ub32  = b[31:0];
    sa32  = a[31:0];
    sb32  = b[31:0];
    ovf64 = (a == 64'h8000_0000_0000_0000) && (b == '1);  // most negative / -1
    ovf32 = (ua32 == 32'h8000_0000) && (ub32 == 32'hffff_ffff);
    case (op)
      OP_MUL:    return a * b;
      OP_MULH: begin
        sp = sa * sb;
        return sp[127:64];
      end
      OP_MULHSU: begin
        sp = sa * $signed(ub);
        return sp[127:64];
      end
      OP_MULHU: begin
        up = ua * ub;
        return up[127:64];
      end
      OP_MULW:   return sext_word(ua32 * ub32);
      OP_DIV:    return (b == '0) ? '1 : (ovf64 ? a : xlen_t'(sa64 / sb64));
      OP_DIVU:   return (b == '0) ? '1 : a / b;
      OP_DIVW:   return (ub32 == '0) ? '1 : (ovf32 ? sext_word(ua32) : sext_word(sa32 / sb32));
      OP_DIVUW:  return (ub32 == '0) ? '1 : sext_word(ua32 / ub32);
      OP_REM:    return (b == '0) ? a : (ovf64 ? '0 : xlen_t'(sa64 % sb64));
      OP_REMU:   return (b == '0) ? a : a % b;
      OP_REMW:   return (ub32 == '0) ? sext_word(ua32) : (ovf32 ? '0 : sext_word(sa32 % sb32));
      OP_REMUW:  return (ub32 == '0) ? sext_word(ua32) : sext_word(ua32 % ub32);
      default:   return '0;
    endcase
  endfunction

  // sampled mid-cycle while the inputs are stable
  always @(negedge clk) begin
    if (!rst_n && res_ok_i && res_ready_i) begin
      if (!pending[res_tag_i]) begin
        $display("%0t: result came back with tag %0d but no request with that tag is open",
                 $time, res_tag_i);
        err_cnt++;
      end else begin
        if (res_data_i !== exp_data[res_tag_i]) begin
          $display("[ERROR] %0t res_data_o expected %h got %h for tag %0d",
                   $time, exp_data[res_tag_i], res_data_i, res_tag_i);
          err_cnt++;
        end
        pending[res_tag_i] = 1'b0;
        pend_cnt--;
      end
      res_cnt++;
      last_tag = res_tag_i;
    end
    if (!rst_n && req_valid_i && !stall_i) begin
      if (pending[req_tag_i]) begin
        $display("%0t: tag %0d accepted again while its earlier request is still open",
                 $time, req_tag_i);
        err_cnt++;
      end else begin
        pend_cnt++;
      end
      pending[req_tag_i]  = 1'b1;
      exp_data[req_tag_i] = isa_result(req_op_i, req_a_i, req_b_i);
    end
  end

  assign pend_cnt_o = pend_cnt;
  assign res_cnt_o  = res_cnt;
  assign err_cnt_o  = err_cnt;
  assign last_tag_o = last_tag;

endmodule

`default_nettype wire

// ==== verification/tb_muldiv_unit.sv ====
// muldiv unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_muldiv_unit;
  import muldiv_pkg::*;

  logic    clk         = 1'b0;
  logic    rst_n       = 1'b1;  // high holds the unit in reset
  logic    req_valid_i = 1'b0;
  md_op_t  req_op_i    = OP_MUL;
  xlen_t   req_a_i     = '0;
  xlen_t   req_b_i     = '0;
  md_tag_t req_tag_i   = '0;
  logic    res_ready_i = 1'b0;
  logic    stall_o;
  logic    res_ok_o;
  xlen_t   res_data_o;
  md_tag_t res_tag_o;

  int      pend_cnt, res_cnt, chk_errs;
  md_tag_t last_tag;
  int      tb_errs    = 0;
  int      errs_seen  = 0;
  int      last_waits = 0;  // stall cycles seen by the latest request
  logic    hold_ready = 1'b0;  // forces back-pressure
  md_tag_t next_tag   = '0;

  md_op_t ops [13] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW,
                       OP_DIV, OP_DIVU, OP_DIVW, OP_DIVUW,
                       OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  md_op_t word_ops [5] = '{OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};

  always #2 clk = ~clk;

  always @(posedge clk) begin
    res_ready_i <= !hold_ready && (($urandom % 10) < 7);  // about 70 percent
  end

  muldiv_unit i_dut (
    .clk(clk), .rst_n(rst_n),
    .req_valid_i(req_valid_i), .req_op_i(req_op_i),
    .req_a_i(req_a_i), .req_b_i(req_b_i), .req_tag_i(req_tag_i),
    .stall_o(stall_o),
    .res_ok_o(res_ok_o), .res_data_o(res_data_o), .res_tag_o(res_tag_o),
    .res_ready_i(res_ready_i)
  );

  md_checker i_chk (
    .clk(clk), .rst_n(rst_n),
    .req_valid_i(req_valid_i), .req_op_i(req_op_i),
    .req_a_i(req_a_i), .req_b_i(req_b_i), .req_tag_i(req_tag_i), .stall_i(stall_o),
    .res_ok_i(res_ok_o), .res_data_i(res_data_o), .res_tag_i(res_tag_o),
    .res_ready_i(res_ready_i),
    .pend_cnt_o(pend_cnt), .res_cnt_o(res_cnt), .err_cnt_o(chk_errs), .last_tag_o(last_tag)
  );

  // ==========================================================
  // helpers start and end just after a rising edge
  // ==========================================================
  task automatic issue_req(input md_op_t op, input xlen_t a, input xlen_t b);
    int waited;
    waited = 0;
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_a_i     <= a;
    req_b_i     <= b;
    req_tag_i   <= next_tag;
    next_tag    <= next_tag + 3'd1;
    @(negedge clk);
    while (stall_o && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    last_waits = waited;
    if (stall_o) begin
      $display("%0t: timeout, request with op %h never left the stall", $time, op);
      tb_errs++;
    end
    @(posedge clk);  // taken here
  endtask

  task automatic wait_results(input int target, input string what);
    int waited;
    waited = 0;
    while (res_cnt < target && waited < 200) begin
      @(posedge clk);
      waited++;
    end
    if (res_cnt < target) begin
      $display("%0t: timeout waiting for %s", $time, what);
      tb_errs++;
    end
  endtask

  task automatic expect_eq(input string sig, input xlen_t exp, input xlen_t got);
    if (got !== exp) begin
      $display("[ERROR] %0t %s expected %h got %h", $time, sig, exp, got);
      tb_errs++;
    end
  endtask

  task automatic end_test(input string name);
    $display("done: %s, errors %0d", name, tb_errs + chk_errs - errs_seen);
    errs_seen = tb_errs + chk_errs;
  endtask

  // ==========================================================
  // test sequence
  // ==========================================================
  initial begin
    xlen_t   held_data;
    md_tag_t held_tag, t_mul, t_div;
    int      base, waited;
    logic    is_word;
    void'($urandom(32'heecb_63a0));
    repeat (2) @(posedge clk);
    rst_n <= 1'b0;

    @(negedge clk);
    expect_eq("res_ok_o", 64'd0, xlen_t'(res_ok_o));
    expect_eq("stall_o", 64'd0, xlen_t'(stall_o));
    @(posedge clk);
    end_test("idle after reset");

    repeat (60) begin
      issue_req(ops[$urandom % 13], {$urandom, $urandom},
                (($urandom % 4) == 0) ? xlen_t'($urandom % 16) : {$urandom, $urandom});
    end
    req_valid_i <= 1'b0;
    wait_results(res_cnt + pend_cnt, "random results");
    end_test("random operands, all operations");

    for (int i = 5; i < 13; i++) begin
      is_word = ops[i] inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
      issue_req(ops[i], {$urandom, $urandom}, is_word ? {$urandom, 32'h0} : 64'h0);
      issue_req(ops[i], is_word ? {$urandom, 32'h8000_0000} : 64'h8000_0000_0000_0000,
                is_word ? {$urandom, 32'hffff_ffff} : 64'hffff_ffff_ffff_ffff);
    end
    req_valid_i <= 1'b0;
    wait_results(res_cnt + pend_cnt, "exception results");
    end_test("divide by zero and overflow");

    repeat (20) begin
      issue_req(word_ops[$urandom % 5], {$urandom, $urandom}, {$urandom, $urandom});
    end
    req_valid_i <= 1'b0;
    wait_results(res_cnt + pend_cnt, "word results");
    end_test("word forms");

    // multiply then divide on consecutive edges
    base  = res_cnt;
    t_mul = next_tag;
    issue_req(OP_MULHU, {$urandom, $urandom}, {$urandom, $urandom});
    t_div = next_tag;
    issue_req(OP_DIVU, {$urandom, $urandom}, {32'h0, $urandom} | 64'h1);
    if (last_waits != 0) begin
      $display("%0t: divide was stalled %0d cycles behind the multiply", $time, last_waits);
      tb_errs++;
    end
    req_valid_i <= 1'b0;
    wait_results(base + 1, "first back-to-back result");
    expect_eq("res_tag_o", xlen_t'(t_mul), xlen_t'(last_tag));
    wait_results(base + 2, "second back-to-back result");
    expect_eq("res_tag_o", xlen_t'(t_div), xlen_t'(last_tag));
    end_test("back-to-back multiply and divide");

    // divider result waits while the multiplier finishes beside it
    hold_ready <= 1'b1;
    issue_req(OP_DIV, {$urandom, $urandom}, {$urandom, $urandom} | 64'h1);
    req_valid_i <= 1'b0;
    @(negedge clk);
    for (waited = 0; !res_ok_o && waited < 200; waited++) @(negedge clk);
    if (!res_ok_o) begin
      $display("%0t: timeout waiting for res_ok_o while res_ready_i is low", $time);
      tb_errs++;
    end
    held_data = res_data_o;
    held_tag  = res_tag_o;
    @(posedge clk);
    issue_req(OP_MUL, {$urandom, $urandom}, {$urandom, $urandom});  // multiplier still free
    req_op_i <= OP_REMU;  // the waiting engine must stall
    repeat (80) begin
      @(negedge clk);
      expect_eq("res_ok_o", 64'd1, xlen_t'(res_ok_o));
      expect_eq("res_data_o", held_data, res_data_o);
      expect_eq("res_tag_o", xlen_t'(held_tag), xlen_t'(res_tag_o));
      expect_eq("stall_o", 64'd1, xlen_t'(stall_o));
    end
    @(posedge clk);
    req_valid_i <= 1'b0;
    hold_ready  <= 1'b0;
    wait_results(res_cnt + pend_cnt, "results held by back-pressure");
    end_test("back-pressure");

    $display("results checked %0d, errors %0d", res_cnt, tb_errs + chk_errs);
    if (tb_errs + chk_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== muldiv_unit.f ====
rtl/muldiv_pkg.sv
rtl/md_dispatch.sv
rtl/md_divider.sv
rtl/md_multiplier.sv
rtl/md_result_arbiter.sv
rtl/muldiv_unit.sv
verification/md_checker.sv
verification/tb_muldiv_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the muldiv_unit testbench with verilator, run it, then grep the log
cd "$(dirname "$0")" && rm -f sim.log &&
verilator --binary --timing -Wno-fatal --top-module tb_muldiv_unit \
  -f muldiv_unit.f -o sim_muldiv > build.log 2>&1 &&
./obj_dir/sim_muldiv > sim.log 2>&1
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
